// ==== include/dsp_config.svh ====
`ifndef DSP_CONFIG_SVH
`define DSP_CONFIG_SVH

// Symbols per clock
`define DSP_LANES      4

// ADC code and FFE
`define DSP_CODE_W     8
`define DSP_FFE_TAPS   3
`define DSP_WEIGHT_W   6
`define DSP_FFE_W      10
`define DSP_SHIFT_W    3

// Channel estimate, main cursor at tap 0
`define DSP_CHAN_DEPTH 3
`define DSP_CHAN_W     8
`define DSP_EST_W      10

`define DSP_ERR_W      11

`endif

// ==== hdl/dsp_pkg.sv ====
`include "dsp_config.svh"

package dsp_pkg;

    typedef logic signed [`DSP_CODE_W-1:0]   code_t;
    typedef logic signed [`DSP_WEIGHT_W-1:0] weight_t;
    typedef logic signed [`DSP_FFE_W-1:0]    ffe_out_t;
    typedef logic signed [`DSP_CHAN_W-1:0]   chan_tap_t;
    typedef logic signed [`DSP_EST_W-1:0]    est_code_t;
    typedef logic signed [`DSP_ERR_W-1:0]    err_t;
    typedef logic [`DSP_SHIFT_W-1:0]         shift_t;

    // Detector decision per symbol
    typedef enum logic [1:0] {
        DEC_KEEP     = 2'd0,
        DEC_FLIP_ONE = 2'd1,
        DEC_FLIP_TWO = 2'd2
    } decision_e;

endpackage

// ==== hdl/sample_history.sv ====
`timescale 1ns/1ns
`include "dsp_config.svh"

module sample_history #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic [WIDTH-1:0] data_i [`DSP_LANES-1:0],
    output logic [WIDTH-1:0] data_o [`DSP_LANES-1:0]
);

    logic [WIDTH-1:0] stage_q [DEPTH-1:0][`DSP_LANES-1:0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int s = 0; s < DEPTH; s++) begin
                for (int l = 0; l < `DSP_LANES; l++) begin
                    stage_q[s][l] <= '0;
                end
            end
        end else begin
            stage_q[0] <= data_i;
            for (int s = 1; s < DEPTH; s++) begin
                stage_q[s] <= stage_q[s-1];
            end
        end
    end

    // Oldest stage
    assign data_o = stage_q[DEPTH-1];

endmodule

// ==== hdl/ffe_filter.sv ====
`timescale 1ns/1ns
`include "dsp_config.svh"

module ffe_filter (
    input  logic              clk,
    input  logic              rst_i,
    input  dsp_pkg::code_t    codes_i     [`DSP_LANES-1:0],
    input  dsp_pkg::weight_t  weights_i   [`DSP_FFE_TAPS-1:0][`DSP_LANES-1:0],
    input  dsp_pkg::shift_t   ffe_shift_i [`DSP_LANES-1:0],
    output dsp_pkg::ffe_out_t eq_o        [`DSP_LANES-1:0]
);

    localparam int HIST  = `DSP_FFE_TAPS - 1;
    localparam int ACC_W = `DSP_CODE_W + `DSP_WEIGHT_W + $clog2(`DSP_FFE_TAPS) + 1;

    localparam logic signed [ACC_W-1:0] SAT_MAX = 2 ** (`DSP_FFE_W - 1) - 1;
    localparam logic signed [ACC_W-1:0] SAT_MIN = -(2 ** (`DSP_FFE_W - 1));

    // Tail of the previous cycle, oldest first
    dsp_pkg::code_t          hist_q  [HIST-1:0];
    dsp_pkg::code_t          window  [`DSP_LANES+HIST-1:0];
    logic signed [ACC_W-1:0] acc     [`DSP_LANES-1:0];
    logic signed [ACC_W-1:0] shifted [`DSP_LANES-1:0];
    dsp_pkg::ffe_out_t       eq_d    [`DSP_LANES-1:0];

    always_comb begin
        for (int i = 0; i < HIST; i++) begin
            window[i] = hist_q[i];
        end
        for (int i = 0; i < `DSP_LANES; i++) begin
            window[i+HIST] = codes_i[i];
        end
        for (int l = 0; l < `DSP_LANES; l++) begin
            acc[l] = '0;
            for (int k = 0; k < `DSP_FFE_TAPS; k++) begin
                acc[l] = acc[l] + weights_i[k][l] * window[l+HIST-k];
            end
            shifted[l] = acc[l] >>> ffe_shift_i[l];
            if (shifted[l] > SAT_MAX) begin
                eq_d[l] = SAT_MAX[`DSP_FFE_W-1:0];
            end else if (shifted[l] < SAT_MIN) begin
                eq_d[l] = SAT_MIN[`DSP_FFE_W-1:0];
            end else begin
                eq_d[l] = shifted[l][`DSP_FFE_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < HIST; i++) begin
                hist_q[i] <= '0;
            end
            for (int l = 0; l < `DSP_LANES; l++) begin
                eq_o[l] <= '0;
            end
        end else begin
            for (int i = 0; i < HIST; i++) begin
                hist_q[i] <= codes_i[`DSP_LANES-HIST+i];
            end
            eq_o <= eq_d;
        end
    end

endmodule

// ==== hdl/bit_slicer.sv ====
`timescale 1ns/1ns
`include "dsp_config.svh"

module bit_slicer (
    input  logic              clk,
    input  logic              rst_i,
    input  dsp_pkg::ffe_out_t eq_i     [`DSP_LANES-1:0],
    input  dsp_pkg::ffe_out_t thresh_i [`DSP_LANES-1:0],
    output logic              bits_o   [`DSP_LANES-1:0]
);

    logic bits_d [`DSP_LANES-1:0];

    // Signed compare, threshold itself slices to one
    always_comb begin
        for (int l = 0; l < `DSP_LANES; l++) begin
            bits_d[l] = (eq_i[l] >= thresh_i[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int l = 0; l < `DSP_LANES; l++) begin
                bits_o[l] <= 1'b0;
            end
        end else begin
            bits_o <= bits_d;
        end
    end

endmodule

// ==== hdl/channel_filter.sv ====
`timescale 1ns/1ns
`include "dsp_config.svh"

module channel_filter (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               bits_i       [`DSP_LANES-1:0],
    input  dsp_pkg::chan_tap_t chan_taps_i  [`DSP_LANES-1:0][`DSP_CHAN_DEPTH-1:0],
    input  dsp_pkg::shift_t    chan_shift_i [`DSP_LANES-1:0],
    output dsp_pkg::est_code_t est_o        [`DSP_LANES-1:0]
);

    localparam int HIST  = `DSP_CHAN_DEPTH - 1;
    localparam int ACC_W = `DSP_CHAN_W + $clog2(`DSP_CHAN_DEPTH) + 1;

    logic                    bits_q  [HIST-1:0];
    logic                    bit_win [`DSP_LANES+HIST-1:0];
    logic signed [ACC_W-1:0] acc     [`DSP_LANES-1:0];
    logic signed [ACC_W-1:0] shifted [`DSP_LANES-1:0];

    always_comb begin
        for (int i = 0; i < HIST; i++) begin
            bit_win[i] = bits_q[i];
        end
        for (int i = 0; i < `DSP_LANES; i++) begin
            bit_win[i+HIST] = bits_i[i];
        end
        // Bit 1 adds the tap, bit 0 subtracts it
        for (int l = 0; l < `DSP_LANES; l++) begin
            acc[l] = '0;
            for (int k = 0; k < `DSP_CHAN_DEPTH; k++) begin
                if (bit_win[l+HIST-k]) begin
                    acc[l] = acc[l] + chan_taps_i[l][k];
                end else begin
                    acc[l] = acc[l] - chan_taps_i[l][k];
                end
            end
            shifted[l] = acc[l] >>> chan_shift_i[l];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < HIST; i++) begin
                bits_q[i] <= 1'b0;
            end
            for (int l = 0; l < `DSP_LANES; l++) begin
                est_o[l] <= '0;
            end
        end else begin
            for (int i = 0; i < HIST; i++) begin
                bits_q[i] <= bits_i[`DSP_LANES-HIST+i];
            end
            for (int l = 0; l < `DSP_LANES; l++) begin
                est_o[l] <= shifted[l][`DSP_EST_W-1:0];
            end
        end
    end

endmodule

// ==== hdl/sliding_detector.sv ====
`timescale 1ns/1ns
`include "dsp_config.svh"

module sliding_detector (
    input  logic                clk,
    input  logic                rst_i,
    input  dsp_pkg::est_code_t  est_i           [`DSP_LANES-1:0],
    input  dsp_pkg::code_t      codes_i         [`DSP_LANES-1:0],
    input  logic                bits_i          [`DSP_LANES-1:0],
    input  dsp_pkg::chan_tap_t  chan_taps_i     [`DSP_LANES-1:0][`DSP_CHAN_DEPTH-1:0],
    input  dsp_pkg::shift_t     chan_shift_i    [`DSP_LANES-1:0],
    output dsp_pkg::err_t       errors_o        [`DSP_LANES-1:0],
    output dsp_pkg::decision_e  decisions_o     [`DSP_LANES-1:0],
    output logic                decision_bits_o [`DSP_LANES-1:0]
);

    // Symbols n to n+3 enter each cost
    localparam int WIN    = 4;
    localparam int TERM_W = `DSP_CHAN_W + 2;
    localparam int DIFF_W = `DSP_ERR_W + 2;
    localparam int COST_W = 2 * DIFF_W + 2;

    dsp_pkg::err_t            err_prev_q  [`DSP_LANES-1:0];
    logic                     bits_prev_q [`DSP_LANES-1:0];
    dsp_pkg::err_t            e_win       [2*`DSP_LANES-1:0];
    logic                     b_win       [`DSP_LANES:0];
    logic signed [COST_W-1:0] cost0       [`DSP_LANES-1:0];
    logic signed [COST_W-1:0] cost1       [`DSP_LANES-1:0];
    logic signed [COST_W-1:0] cost2       [`DSP_LANES-1:0];
    dsp_pkg::decision_e       dec_d       [`DSP_LANES-1:0];

    // Change of a channel term when one bit is flipped
    function automatic logic signed [TERM_W-1:0] flip_term(
        input dsp_pkg::chan_tap_t tap,
        input dsp_pkg::shift_t    shamt,
        input logic               b
    );
        logic signed [TERM_W-1:0] prod;
        prod = tap;
        prod = prod <<< 1;
        if (!b) begin
            prod = -prod;
        end
        return prod >>> shamt;
    endfunction

    always_comb begin : cost_calc
        logic signed [DIFF_W-1:0] e;
        logic signed [DIFF_W-1:0] t1;
        logic signed [DIFF_W-1:0] t2;
        for (int i = 0; i < `DSP_LANES; i++) begin
            e_win[i]            = err_prev_q[i];
            e_win[i+`DSP_LANES] = errors_o[i];
            b_win[i]            = bits_prev_q[i];
        end
        b_win[`DSP_LANES] = bits_i[0];
        for (int n = 0; n < `DSP_LANES; n++) begin
            cost0[n] = '0;
            cost1[n] = '0;
            cost2[n] = '0;
            for (int j = 0; j < WIN; j++) begin
                e  = e_win[n+j];
                t1 = '0;
                t2 = '0;
                if (j < `DSP_CHAN_DEPTH) begin
                    t1 = flip_term(chan_taps_i[(n+j)%`DSP_LANES][j],
                                   chan_shift_i[(n+j)%`DSP_LANES], b_win[n]);
                end
                if (j >= 1 && j - 1 < `DSP_CHAN_DEPTH) begin
                    t2 = flip_term(chan_taps_i[(n+j)%`DSP_LANES][j-1],
                                   chan_shift_i[(n+j)%`DSP_LANES], b_win[n+1]);
                end
                cost0[n] = cost0[n] + e * e;
                cost1[n] = cost1[n] + (e - t1) * (e - t1);
                cost2[n] = cost2[n] + (e - t1 - t2) * (e - t1 - t2);
            end
            // Lowest index wins a tie
            dec_d[n] = dsp_pkg::DEC_KEEP;
            if (cost1[n] < cost0[n]) begin
                dec_d[n] = dsp_pkg::DEC_FLIP_ONE;
            end
            if (cost2[n] < cost0[n] && cost2[n] < cost1[n]) begin
                dec_d[n] = dsp_pkg::DEC_FLIP_TWO;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int l = 0; l < `DSP_LANES; l++) begin
                errors_o[l]        <= '0;
                err_prev_q[l]      <= '0;
                bits_prev_q[l]     <= 1'b0;
                decisions_o[l]     <= dsp_pkg::DEC_KEEP;
                decision_bits_o[l] <= 1'b0;
            end
        end else begin
            for (int l = 0; l < `DSP_LANES; l++) begin
                errors_o[l] <= est_i[l] - codes_i[l];
            end
            err_prev_q      <= errors_o;
            bits_prev_q     <= bits_i;
            decisions_o     <= dec_d;
            decision_bits_o <= bits_prev_q;
        end
    end

endmodule

// ==== hdl/datapath_core.sv ====
`timescale 1ns/1ns
`include "dsp_config.svh"

module datapath_core (
    input  logic               clk,
    input  logic               rst_i,
    input  dsp_pkg::code_t     codes_i         [`DSP_LANES-1:0],
    input  dsp_pkg::weight_t   weights_i       [`DSP_FFE_TAPS-1:0][`DSP_LANES-1:0],
    input  dsp_pkg::shift_t    ffe_shift_i     [`DSP_LANES-1:0],
    input  dsp_pkg::ffe_out_t  thresh_i        [`DSP_LANES-1:0],
    input  dsp_pkg::chan_tap_t chan_taps_i     [`DSP_LANES-1:0][`DSP_CHAN_DEPTH-1:0],
    input  dsp_pkg::shift_t    chan_shift_i    [`DSP_LANES-1:0],
    output logic               sliced_bits_o   [`DSP_LANES-1:0],
    output dsp_pkg::err_t      errors_o        [`DSP_LANES-1:0],
    output dsp_pkg::decision_e decisions_o     [`DSP_LANES-1:0],
    output logic               decision_bits_o [`DSP_LANES-1:0]
);

    dsp_pkg::ffe_out_t        eq_values     [`DSP_LANES-1:0];
    logic                     sliced_bits   [`DSP_LANES-1:0];
    dsp_pkg::est_code_t       est_codes     [`DSP_LANES-1:0];
    logic [`DSP_CODE_W-1:0]   codes_raw     [`DSP_LANES-1:0];
    logic [`DSP_CODE_W-1:0]   codes_dly_raw [`DSP_LANES-1:0];
    dsp_pkg::code_t           codes_dly     [`DSP_LANES-1:0];
    logic                     bits_dly      [`DSP_LANES-1:0];

    // Delay line stores codes as plain vectors
    for (genvar g = 0; g < `DSP_LANES; g++) begin : g_code_cast
        assign codes_raw[g] = codes_i[g];
        assign codes_dly[g] = codes_dly_raw[g];
    end

    assign sliced_bits_o = sliced_bits;

    ffe_filter ffe (
        .clk         (clk),
        .rst_i       (rst_i),
        .codes_i     (codes_i),
        .weights_i   (weights_i),
        .ffe_shift_i (ffe_shift_i),
        .eq_o        (eq_values)
    );

    bit_slicer slicer (
        .clk      (clk),
        .rst_i    (rst_i),
        .eq_i     (eq_values),
        .thresh_i (thresh_i),
        .bits_o   (sliced_bits)
    );

    channel_filter chan_filt (
        .clk          (clk),
        .rst_i        (rst_i),
        .bits_i       (sliced_bits),
        .chan_taps_i  (chan_taps_i),
        .chan_shift_i (chan_shift_i),
        .est_o        (est_codes)
    );

    // Codes line up with est_codes, three cycles after entry
    sample_history #(.WIDTH(`DSP_CODE_W), .DEPTH(3)) code_delay (
        .clk    (clk),
        .rst_i  (rst_i),
        .data_i (codes_raw),
        .data_o (codes_dly_raw)
    );

    // Bits line up with the registered errors
    sample_history #(.WIDTH(1), .DEPTH(2)) bit_delay (
        .clk    (clk),
        .rst_i  (rst_i),
        .data_i (sliced_bits),
        .data_o (bits_dly)
    );

    sliding_detector detector (
        .clk             (clk),
        .rst_i           (rst_i),
        .est_i           (est_codes),
        .codes_i         (codes_dly),
        .bits_i          (bits_dly),
        .chan_taps_i     (chan_taps_i),
        .chan_shift_i    (chan_shift_i),
        .errors_o        (errors_o),
        .decisions_o     (decisions_o),
        .decision_bits_o (decision_bits_o)
    );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk_o = ~clk_o;
        end
    end

    // Released on a falling edge, like every other DUT input
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// ==== bench/datapath_sva.sv ====
`timescale 1ns/1ns
`include "dsp_config.svh"

module datapath_sva (
    input logic               clk,
    input logic               rst_i,
    input logic               sliced_bits_i   [`DSP_LANES-1:0],
    input dsp_pkg::err_t      errors_i        [`DSP_LANES-1:0],
    input dsp_pkg::decision_e decisions_i     [`DSP_LANES-1:0],
    input logic               decision_bits_i [`DSP_LANES-1:0]
);

    for (genvar l = 0; l < `DSP_LANES; l++) begin : g_lane
        // Synchronous reset clears every output
        assert property (@(posedge clk) rst_i |=>
                         (sliced_bits_i[l] == 1'b0 && errors_i[l] == '0 &&
                          decisions_i[l] == dsp_pkg::DEC_KEEP && decision_bits_i[l] == 1'b0))
            else $error("lane %0d outputs not cleared after reset", l);

        // Encoding 3 is unused
        assert property (@(posedge clk) disable iff (rst_i) 2'(decisions_i[l]) != 2'b11)
            else $error("lane %0d decision holds the unused encoding", l);

        // Bit delay plus detector register
        assert property (@(posedge clk) disable iff (rst_i)
                         decision_bits_i[l] == $past(sliced_bits_i[l], 4))
            else $error("lane %0d decision bit does not follow sliced bit", l);
    end

endmodule

// ==== bench/datapath_tb.sv ====
`timescale 1ns/1ns
`include "dsp_config.svh"

module datapath_tb;

    localparam int LANES          = `DSP_LANES;
    localparam int TAPS           = `DSP_FFE_TAPS;
    localparam int DEPTH          = `DSP_CHAN_DEPTH;
    localparam int TEST_CYC       = 64;
    localparam int CYC_PER_TEST   = TEST_CYC + 8;
    localparam int NUM_TESTS      = 5;
    localparam int TOTAL          = NUM_TESTS * CYC_PER_TEST;
    localparam int SYM            = CYC_PER_TEST * LANES;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL + 32;
    localparam int FFE_MAX        = 2 ** (`DSP_FFE_W - 1) - 1;
    localparam int FFE_MIN        = -(2 ** (`DSP_FFE_W - 1));

    logic clk;
    logic rst;

    dsp_pkg::code_t     codes       [LANES-1:0];
    dsp_pkg::weight_t   weights     [TAPS-1:0][LANES-1:0];
    dsp_pkg::shift_t    ffe_shift   [LANES-1:0];
    dsp_pkg::ffe_out_t  thresh      [LANES-1:0];
    dsp_pkg::chan_tap_t chan_taps   [LANES-1:0][DEPTH-1:0];
    dsp_pkg::shift_t    chan_shift  [LANES-1:0];
    logic               sliced_bits [LANES-1:0];
    dsp_pkg::err_t      errors      [LANES-1:0];
    dsp_pkg::decision_e decisions   [LANES-1:0];
    logic               dec_bits    [LANES-1:0];

    // Configuration of the test being prepared, applied with its first cycle
    dsp_pkg::weight_t   cfg_weights    [TAPS-1:0][LANES-1:0];
    dsp_pkg::shift_t    cfg_ffe_shift  [LANES-1:0];
    dsp_pkg::ffe_out_t  cfg_thresh     [LANES-1:0];
    dsp_pkg::chan_tap_t cfg_taps       [LANES-1:0][DEPTH-1:0];
    dsp_pkg::shift_t    cfg_chan_shift [LANES-1:0];

    dsp_pkg::code_t     code_sym [0:TOTAL*LANES-1];
    logic               exp_bit  [0:TOTAL*LANES-1];
    dsp_pkg::err_t      exp_err  [0:TOTAL*LANES-1];
    dsp_pkg::decision_e exp_dec  [0:TOTAL*LANES-1];
    logic               chk_bit  [0:TOTAL-1];
    logic               chk_rest [0:TOTAL-1];
    int                 cyc_test [0:TOTAL-1];
    int                 test_checks [NUM_TESTS];
    int                 test_errors [NUM_TESTS];
    logic               compare_done;
    logic [31:0]        rng_state;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(RESET_CYCLES)) clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    datapath_core dut (
        .clk             (clk),
        .rst_i           (rst),
        .codes_i         (codes),
        .weights_i       (weights),
        .ffe_shift_i     (ffe_shift),
        .thresh_i        (thresh),
        .chan_taps_i     (chan_taps),
        .chan_shift_i    (chan_shift),
        .sliced_bits_o   (sliced_bits),
        .errors_o        (errors),
        .decisions_o     (decisions),
        .decision_bits_o (dec_bits)
    );

    bind datapath_core datapath_sva sva (
        .clk             (clk),
        .rst_i           (rst_i),
        .sliced_bits_i   (sliced_bits_o),
        .errors_i        (errors_o),
        .decisions_i     (decisions_o),
        .decision_bits_i (decision_bits_o)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic dsp_pkg::code_t random_code();
        logic [31:0] r;
        r = next_random();
        return r[7:0];
    endfunction

    function automatic int bit_sign(input logic b);
        return b ? 1 : -1;
    endfunction

    // Change in the channel sum of a lane when the bit k symbols back flips
    function automatic int flip_delta(input int lane, input int k, input logic b);
        return (2 * bit_sign(b) * cfg_taps[lane][k]) >>> cfg_chan_shift[lane];
    endfunction

    function automatic void reference_model(input int t, input int base);
        int x [0:SYM-1];
        int e [0:SYM-1];
        logic b [0:SYM-1];
        int cost [0:2];
        int acc;
        int l;
        int d1;
        int d2;
        int best;
        dsp_pkg::est_code_t est;
        for (int i = 0; i < SYM; i++) begin
            x[i] = code_sym[base*LANES+i];
        end
        for (int i = 0; i < SYM; i++) begin
            l = i % LANES;
            acc = 0;
            for (int k = 0; k < TAPS; k++) begin
                if (i - k >= 0) begin
                    acc = acc + cfg_weights[k][l] * x[i-k];
                end
            end
            acc = acc >>> cfg_ffe_shift[l];
            if (acc > FFE_MAX) begin
                acc = FFE_MAX;
            end else if (acc < FFE_MIN) begin
                acc = FFE_MIN;
            end
            b[i] = (acc >= cfg_thresh[l]);
            exp_bit[base*LANES+i] = b[i];
        end
        // Bits before the stream count as 0
        for (int i = 0; i < SYM; i++) begin
            l = i % LANES;
            acc = 0;
            for (int k = 0; k < DEPTH; k++) begin
                acc = acc + cfg_taps[l][k] * ((i - k >= 0) ? bit_sign(b[i-k]) : -1);
            end
            est = acc >>> cfg_chan_shift[l];
            e[i] = est - x[i];
            exp_err[base*LANES+i] = e[i];
        end
        for (int n = 0; n + 4 <= SYM; n++) begin
            cost = '{0, 0, 0};
            for (int j = 0; j < 4; j++) begin
                l = (n + j) % LANES;
                d1 = (j < DEPTH) ? flip_delta(l, j, b[n]) : 0;
                d2 = d1;
                if (j >= 1 && j - 1 < DEPTH) begin
                    d2 = d1 + flip_delta(l, j - 1, b[n+1]);
                end
                cost[0] = cost[0] + e[n+j] * e[n+j];
                cost[1] = cost[1] + (e[n+j] - d1) * (e[n+j] - d1);
                cost[2] = cost[2] + (e[n+j] - d2) * (e[n+j] - d2);
            end
            best = 0;
            if (cost[1] < cost[best]) begin
                best = 1;
            end
            if (cost[2] < cost[best]) begin
                best = 2;
            end
            exp_dec[base*LANES+n] = dsp_pkg::decision_e'(best);
        end
        // First cycle leans on bits from before the change
        for (int c = 0; c < CYC_PER_TEST; c++) begin
            cyc_test[base+c] = t;
            chk_bit[base+c]  = (c < TEST_CYC);
            chk_rest[base+c] = (c >= 1 && c < TEST_CYC);
        end
    endfunction

    task automatic check_bit(input string sig, input int c, input int l,
                             input logic got, input logic exp);
        test_checks[cyc_test[c]]++;
        if (got !== exp) begin
            $display("[ERROR] %s[%0d] cycle %0d: got %h, expected %h", sig, l, c, got, exp);
            test_errors[cyc_test[c]]++;
        end
    endtask

    task automatic check_err(input int c, input int l,
                             input dsp_pkg::err_t got, input dsp_pkg::err_t exp);
        test_checks[cyc_test[c]]++;
        if (got !== exp) begin
            $display("[ERROR] errors_o[%0d] cycle %0d: got %h, expected %h", l, c, got, exp);
            test_errors[cyc_test[c]]++;
        end
    endtask

    task automatic check_decision(input int c, input int l,
                                  input dsp_pkg::decision_e got, input dsp_pkg::decision_e exp);
        test_checks[cyc_test[c]]++;
        if (got !== exp) begin
            $display("[ERROR] decisions_o[%0d] cycle %0d: got %h, expected %h", l, c, got, exp);
            test_errors[cyc_test[c]]++;
        end
    endtask

    task automatic set_identity_ffe();
        for (int l = 0; l < LANES; l++) begin
            for (int k = 0; k < TAPS; k++) begin
                cfg_weights[k][l] = (k == 0) ? 6'sd1 : 6'sd0;
            end
            cfg_ffe_shift[l] = '0;
            cfg_thresh[l]    = '0;
        end
    endtask

    task automatic set_default_channel();
        for (int l = 0; l < LANES; l++) begin
            cfg_taps[l][0]    = 8'sd56;
            cfg_taps[l][1]    = 8'sd18;
            cfg_taps[l][2]    = -8'sd8;
            cfg_chan_shift[l] = 3'd1;
        end
    endtask

    task automatic build_stimulus(input int t, input int base);
        logic [31:0] r;
        logic gen_bits [0:TEST_CYC*LANES-1];
        int acc;
        int l;
        int mag;
        set_identity_ffe();
        set_default_channel();
        for (int l2 = 0; l2 < LANES; l2++) begin
            for (int k = 0; k < TAPS; k++) begin
                r = next_random();
                if (t == 1) begin
                    cfg_weights[k][l2] = r[5:0];
                end
            end
            for (int k = 0; k < DEPTH; k++) begin
                if (t == 3) begin
                    cfg_taps[l2][k] = random_code();
                end
            end
            r = next_random();
            if (t == 1) begin
                cfg_ffe_shift[l2] = (r[2:0] == 3'd0) ? 3'd1 : r[2:0];
            end
            if (t == 3) begin
                cfg_chan_shift[l2] = r[5:3];
            end
        end
        if (t == 2) begin
            cfg_thresh = '{10'sd64, 10'sd20, -10'sd12, -10'sd48};
        end
        for (int i = 0; i < CYC_PER_TEST * LANES; i++) begin
            code_sym[base*LANES+i] = '0;
        end
        for (int i = 0; i < TEST_CYC * LANES; i++) begin
            l = i % LANES;
            r = next_random();
            if (t == 1) begin
                mag = 96 + r[4:0];
                code_sym[base*LANES+i] = r[5] ? mag : -mag;
            end else if (t == 4) begin
                // Channel output plus a rare large noise hit
                gen_bits[i] = r[0];
                acc = 0;
                for (int k = 0; k < DEPTH; k++) begin
                    acc = acc + cfg_taps[l][k] * ((i - k >= 0) ? bit_sign(gen_bits[i-k]) : -1);
                end
                acc = acc >>> cfg_chan_shift[l];
                if (r[7:4] == 4'd0) begin
                    acc = acc + (r[8] ? (40 + r[13:9]) : -(40 + r[13:9]));
                end
                acc = (acc > 127) ? 127 : ((acc < -128) ? -128 : acc);
                code_sym[base*LANES+i] = acc;
            end else begin
                code_sym[base*LANES+i] = r[15:8];
            end
        end
    endtask

    task automatic run_test(input int t, input string name);
        int base;
        base = t * CYC_PER_TEST;
        build_stimulus(t, base);
        reference_model(t, base);
        for (int c = 0; c < CYC_PER_TEST; c++) begin
            @(negedge clk);
            if (c == 0) begin
                weights    = cfg_weights;
                ffe_shift  = cfg_ffe_shift;
                thresh     = cfg_thresh;
                chan_taps  = cfg_taps;
                chan_shift = cfg_chan_shift;
            end
            for (int l = 0; l < LANES; l++) begin
                codes[l] = code_sym[(base+c)*LANES+l];
            end
        end
        $display("test %0d %s: %0d checks, %0d mismatches, %s", t + 1, name, test_checks[t],
                 test_errors[t], (test_errors[t] == 0) ? "passed" : "failed");
    endtask

    // Outputs sampled on the falling edge, away from the register updates
    initial begin : compare_outputs
        int g;
        @(negedge rst);
        for (int k = 0; k < TOTAL + 6; k++) begin
            @(negedge clk);
            for (int l = 0; l < LANES; l++) begin
                if (k >= 2 && k - 2 < TOTAL && chk_bit[k-2]) begin
                    check_bit("sliced_bits_o", k - 2, l, sliced_bits[l], exp_bit[(k-2)*LANES+l]);
                end
                if (k >= 4 && k - 4 < TOTAL && chk_rest[k-4]) begin
                    check_err(k - 4, l, errors[l], exp_err[(k-4)*LANES+l]);
                end
                if (k >= 6 && chk_rest[k-6]) begin
                    g = (k - 6) * LANES + l;
                    check_decision(k - 6, l, decisions[l], exp_dec[g]);
                    check_bit("decision_bits_o", k - 6, l, dec_bits[l], exp_bit[g]);
                end
            end
        end
        compare_done = 1'b1;
    end

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        int total_checks;
        int total_errors;
        rng_state    = 32'h0f20d70b;
        compare_done = 1'b0;
        codes        = '{default: '0};
        weights      = '{default: '0};
        ffe_shift    = '{default: '0};
        thresh       = '{default: '0};
        chan_taps    = '{default: '0};
        chan_shift   = '{default: '0};
        chk_bit      = '{default: 1'b0};
        chk_rest     = '{default: 1'b0};
        test_checks  = '{default: 0};
        test_errors  = '{default: 0};
        @(negedge rst);
        run_test(0, "identity_ffe");
        run_test(1, "random_weights_saturation");
        run_test(2, "lane_thresholds");
        run_test(3, "random_channel");
        run_test(4, "detector_decisions");
        wait (compare_done);
        total_checks = 0;
        total_errors = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_checks += test_checks[t];
            total_errors += test_errors[t];
        end
        $display("tests %0d, checks %0d, mismatches %0d", NUM_TESTS, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/dsp_pkg.sv
hdl/sample_history.sv
hdl/ffe_filter.sv
hdl/bit_slicer.sv
hdl/channel_filter.sv
hdl/sliding_detector.sv
hdl/datapath_core.sv
bench/tb_clock.sv
bench/datapath_sva.sv
bench/datapath_tb.sv

// ==== Bender.yml ====
package:
  name: datapath_core

sources:
  - include_dirs:
      - include
    files:
      - hdl/dsp_pkg.sv
      - hdl/sample_history.sv
      - hdl/ffe_filter.sv
      - hdl/bit_slicer.sv
      - hdl/channel_filter.sv
      - hdl/sliding_detector.sv
      - hdl/datapath_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_clock.sv
      - bench/datapath_sva.sv
      - bench/datapath_tb.sv
